// File: hdl/ex_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types for the integer execute stage.
// Holds the data width, the opcode and unit encodings, and the
// structs that travel between input, issue slot and EX/WB register.
//////////////////////////////////////////////////////////////////////

package ex_pkg;

  // Data path and register index widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Opcodes accepted on the input
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_SLL  = 4'h5,
    OP_SRL  = 4'h6,
    OP_SLT  = 4'h7,
    OP_SLTU = 4'h8,
    OP_BEQ  = 4'h9,
    OP_BNE  = 4'ha,
    OP_BLT  = 4'hb,
    OP_DIVU = 4'hc,
    OP_REMU = 4'hd
  } ex_op_e;

  // Functional unit serving an instruction
  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_DIV = 1'b1
  } ex_unit_e;

  // Instruction as it arrives on the input
  typedef struct packed {
    ex_op_e                op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       target;
    logic [REG_ADDR_W-1:0] rd;
  } ex_instr_t;

  // Decoded contents of the issue slot
  typedef struct packed {
    ex_unit_e              unit;
    ex_op_e                op;
    logic                  is_branch;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       target;
  } ex_issue_t;

  // EX/WB register contents
  typedef struct packed {
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wdata;
    logic                  is_branch;
    logic                  branch_taken;
    logic [XLEN-1:0]       branch_target;
  } ex_wb_t;

endpackage

// File: hdl/ex_decode.sv
//////////////////////////////////////////////////////////////////////
// Decode and issue slot of the execute stage.
// Accepts one instruction over valid/ready, decodes it and holds it
// until the result stage retires it. Pulses the divider start.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid_i,
  input  ex_pkg::ex_instr_t in_instr_i,
  output logic              in_ready_o,
  input  logic              retire_i,
  output logic              issue_valid_o,
  output ex_pkg::ex_issue_t issue_o,
  output logic              div_start_o
);

  ex_pkg::ex_issue_t issue_d;
  logic              load;

  // Slot takes a new instruction when empty or emptying this cycle
  assign in_ready_o = !issue_valid_o || retire_i;
  assign load       = in_valid_i && in_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    issue_d.op        = in_instr_i.op;
    issue_d.rd        = in_instr_i.rd;
    issue_d.operand_a = in_instr_i.operand_a;
    issue_d.operand_b = in_instr_i.operand_b;
    issue_d.target    = in_instr_i.target;
    // Divide and remainder go to the iterative unit
    issue_d.unit      = (in_instr_i.op == ex_pkg::OP_DIVU || in_instr_i.op == ex_pkg::OP_REMU) ?
                        ex_pkg::UNIT_DIV : ex_pkg::UNIT_ALU;
    issue_d.is_branch = (in_instr_i.op == ex_pkg::OP_BEQ) ||
                        (in_instr_i.op == ex_pkg::OP_BNE) ||
                        (in_instr_i.op == ex_pkg::OP_BLT);
    // No register write for branches or for x0
    issue_d.rf_we     = !issue_d.is_branch && (in_instr_i.rd != '0);
  end

  //////////////////////////////////////////////////////////////////////
  // Issue slot
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid_o <= 1'b0;
      div_start_o   <= 1'b0;
    end else begin
      if (load) begin
        issue_valid_o <= 1'b1;
      end else if (retire_i) begin
        issue_valid_o <= 1'b0;
      end
      // Start pulse lands in the first cycle the divide sits in the slot
      div_start_o <= load && (issue_d.unit == ex_pkg::UNIT_DIV);
    end
  end

  // Slot payload, qualified by issue_valid_o
  always_ff @(posedge clk) begin
    if (load) begin
      issue_o <= issue_d;
    end
  end

endmodule

// File: hdl/ex_alu.sv
//////////////////////////////////////////////////////////////////////
// Single-cycle ALU of the execute stage.
// Computes arithmetic, logic, shift and set-less-than results and
// the branch condition straight from the issue slot.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_alu (
  input  ex_pkg::ex_issue_t          issue_i,
  output logic [ex_pkg::XLEN-1:0]    alu_result_o,
  output logic                       alu_cmp_o
);

  localparam int SHAMT_W = $clog2(ex_pkg::XLEN);

  logic [ex_pkg::XLEN-1:0] op_a;
  logic [ex_pkg::XLEN-1:0] op_b;
  logic [SHAMT_W-1:0]      shamt;
  logic                    lt_signed;
  logic                    lt_unsigned;
  logic                    is_equal;

  assign op_a  = issue_i.operand_a;
  assign op_b  = issue_i.operand_b;
  // Shift amount from the low bits of operand b only
  assign shamt = op_b[SHAMT_W-1:0];

  // Shared comparators for SLT, SLTU and the branches
  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;
  assign is_equal    = op_a == op_b;

  always_comb begin
    case (issue_i.op)
      ex_pkg::OP_ADD:  alu_result_o = op_a + op_b;
      ex_pkg::OP_SUB:  alu_result_o = op_a - op_b;
      ex_pkg::OP_AND:  alu_result_o = op_a & op_b;
      ex_pkg::OP_OR:   alu_result_o = op_a | op_b;
      ex_pkg::OP_XOR:  alu_result_o = op_a ^ op_b;
      ex_pkg::OP_SLL:  alu_result_o = op_a << shamt;
      ex_pkg::OP_SRL:  alu_result_o = op_a >> shamt;
      ex_pkg::OP_SLT:  alu_result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_signed};
      ex_pkg::OP_SLTU: alu_result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_unsigned};
      // Branches and divides produce no ALU data
      default:         alu_result_o = '0;
    endcase
  end

  // Branch condition
  always_comb begin
    case (issue_i.op)
      ex_pkg::OP_BEQ: alu_cmp_o = is_equal;
      ex_pkg::OP_BNE: alu_cmp_o = !is_equal;
      ex_pkg::OP_BLT: alu_cmp_o = lt_signed;
      default:        alu_cmp_o = 1'b0;
    endcase
  end

endmodule

// File: hdl/ex_div.sv
//////////////////////////////////////////////////////////////////////
// Iterative unsigned divider for DIVU and REMU.
// Starts on a one-cycle pulse, retires DIV_BITS_PER_CYCLE quotient
// bits per cycle and holds its result until ready_i is seen.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_div #(
  parameter int DIV_BITS_PER_CYCLE = 1
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start_i,
  input  ex_pkg::ex_op_e          op_i,
  input  logic [ex_pkg::XLEN-1:0] dividend_i,
  input  logic [ex_pkg::XLEN-1:0] divisor_i,
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic [ex_pkg::XLEN-1:0] result_o
);

  localparam int XLEN  = ex_pkg::XLEN;
  localparam int STEPS = XLEN / DIV_BITS_PER_CYCLE;
  localparam int CNT_W = $clog2(STEPS + 1);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } div_state_e;

  div_state_e     state_q;
  logic [CNT_W-1:0] cnt_q;
  // Quotient register starts out holding the dividend and shifts left
  logic [XLEN-1:0]  quo_q;
  logic [XLEN-1:0]  rem_q;
  logic [XLEN-1:0]  divisor_q;
  ex_pkg::ex_op_e   op_q;
  logic [XLEN-1:0]  quo_nxt;
  logic [XLEN-1:0]  rem_nxt;

  //////////////////////////////////////////////////////////////////////
  // Restoring shift-subtract step
  //////////////////////////////////////////////////////////////////////

  // A zero divisor always subtracts, leaving all ones and the dividend
  always_comb begin : step_comb
    logic [XLEN:0] trial;
    rem_nxt = rem_q;
    quo_nxt = quo_q;
    for (int i = 0; i < DIV_BITS_PER_CYCLE; i++) begin
      trial   = {rem_nxt, quo_nxt[XLEN-1]};
      quo_nxt = {quo_nxt[XLEN-2:0], 1'b0};
      if (trial >= {1'b0, divisor_q}) begin
        trial      = trial - {1'b0, divisor_q};
        quo_nxt[0] = 1'b1;
      end
      rem_nxt = trial[XLEN-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: if (start_i) begin
          state_q <= RUN;
          cnt_q   <= CNT_W'(STEPS);
        end
        RUN: begin
          cnt_q <= cnt_q - 1'b1;
          // Last group of bits is done this cycle
          if (cnt_q == CNT_W'(1)) begin
            state_q <= DONE;
          end
        end
        DONE: if (ready_i) begin
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Operands and partial results
  always_ff @(posedge clk) begin
    if (state_q == IDLE && start_i) begin
      quo_q     <= dividend_i;
      rem_q     <= '0;
      divisor_q <= divisor_i;
      op_q      <= op_i;
    end else if (state_q == RUN) begin
      quo_q <= quo_nxt;
      rem_q <= rem_nxt;
    end
  end

  assign valid_o  = (state_q == DONE);
  assign result_o = (op_q == ex_pkg::OP_REMU) ? rem_q : quo_q;

endmodule

// File: hdl/ex_result.sv
//////////////////////////////////////////////////////////////////////
// Result selection and EX/WB output register.
// Retires the slot's instruction once its unit is done and the
// output register can take it, then offers it over valid/ready.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_result (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    issue_valid_i,
  input  ex_pkg::ex_issue_t       issue_i,
  input  logic [ex_pkg::XLEN-1:0] alu_result_i,
  input  logic                    alu_cmp_i,
  input  logic                    div_valid_i,
  input  logic [ex_pkg::XLEN-1:0] div_result_i,
  output logic                    div_ready_o,
  output logic                    retire_o,
  output logic                    out_valid_o,
  output ex_pkg::ex_wb_t          out_wb_o,
  input  logic                    out_ready_i
);

  logic           is_div;
  logic           unit_done;
  ex_pkg::ex_wb_t wb_d;

  assign is_div = (issue_i.unit == ex_pkg::UNIT_DIV);

  // ALU is always done, divider only with its result held
  assign unit_done = is_div ? div_valid_i : 1'b1;

  // Output register is free when empty or draining this cycle
  assign retire_o    = issue_valid_i && unit_done && (!out_valid_o || out_ready_i);
  assign div_ready_o = retire_o && is_div;

  //////////////////////////////////////////////////////////////////////
  // Write mux and branch outcome
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wb_d.rf_we         = issue_i.rf_we;
    wb_d.rd            = issue_i.rd;
    wb_d.wdata         = is_div ? div_result_i : alu_result_i;
    wb_d.is_branch     = issue_i.is_branch;
    wb_d.branch_taken  = issue_i.is_branch && alu_cmp_i;
    // Target is passed on whether taken or not
    wb_d.branch_target = issue_i.target;
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
    end else begin
      if (retire_o) begin
        out_valid_o <= 1'b1;
      end else if (out_ready_i) begin
        // Consumer took the data and nothing follows, so a bubble
        out_valid_o <= 1'b0;
      end
    end
  end

  // Payload held under back-pressure, qualified by out_valid_o
  always_ff @(posedge clk) begin
    if (retire_o) begin
      out_wb_o <= wb_d;
    end
  end

endmodule

// File: hdl/ex_stage.sv
//////////////////////////////////////////////////////////////////////
// Top level of the integer execute stage.
// Connects decode, ALU, divider and result register. The divider
// radix is set here and only changes divide latency.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_stage #(
  parameter int DIV_BITS_PER_CYCLE = 1
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid_i,
  input  ex_pkg::ex_instr_t in_instr_i,
  output logic              in_ready_o,
  output logic              out_valid_o,
  output ex_pkg::ex_wb_t    out_wb_o,
  input  logic              out_ready_i
);

  // Issue slot
  logic                    issue_valid;
  ex_pkg::ex_issue_t       issue;
  logic                    div_start;
  logic                    retire;

  // Unit results
  logic [ex_pkg::XLEN-1:0] alu_result;
  logic                    alu_cmp;
  logic                    div_valid;
  logic                    div_ready;
  logic [ex_pkg::XLEN-1:0] div_result;

  ex_decode u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid_i    (in_valid_i),
    .in_instr_i    (in_instr_i),
    .in_ready_o    (in_ready_o),
    .retire_i      (retire),
    .issue_valid_o (issue_valid),
    .issue_o       (issue),
    .div_start_o   (div_start)
  );

  ex_alu u_alu (
    .issue_i      (issue),
    .alu_result_o (alu_result),
    .alu_cmp_o    (alu_cmp)
  );

  // Operands come from the slot, which holds them for the whole divide
  ex_div #(
    .DIV_BITS_PER_CYCLE (DIV_BITS_PER_CYCLE)
  ) u_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (div_start),
    .op_i       (issue.op),
    .dividend_i (issue.operand_a),
    .divisor_i  (issue.operand_b),
    .valid_o    (div_valid),
    .ready_i    (div_ready),
    .result_o   (div_result)
  );

  ex_result u_result (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid),
    .issue_i       (issue),
    .alu_result_i  (alu_result),
    .alu_cmp_i     (alu_cmp),
    .div_valid_i   (div_valid),
    .div_result_i  (div_result),
    .div_ready_o   (div_ready),
    .retire_o      (retire),
    .out_valid_o   (out_valid_o),
    .out_wb_o      (out_wb_o),
    .out_ready_i   (out_ready_i)
  );

endmodule

// File: verif/tb_ex_stage.sv
//////////////////////////////////////////////////////////////////////
// Directed-test testbench for the integer execute stage.
// Drives instructions over valid/ready, predicts every EX/WB output
// with a reference model and checks order, data and stall stability.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_ex_stage;

  localparam int          RESET_CYCLES = 16;
  localparam logic [31:0] SEED         = 32'd90526;
  localparam int          ALU_REPS     = 4;
  localparam int          NUM_ALU      = 9 * ALU_REPS;
  localparam int          NUM_BRANCH   = 6;
  localparam int          NUM_DIV      = 14;
  localparam int          NUM_MIXED    = 40;
  localparam int          NUM_B2B      = 32;
  localparam int          NUM_INSTR    = NUM_ALU + NUM_BRANCH + NUM_DIV + NUM_MIXED + NUM_B2B;
  // Worst case budget per instruction covers a full divide plus stalls
  localparam int          CYCLE_LIMIT  = NUM_INSTR * (ex_pkg::XLEN + 8) + RESET_CYCLES;

  localparam ex_pkg::ex_op_e ALU_OPS [9] = '{
    ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_AND, ex_pkg::OP_OR, ex_pkg::OP_XOR,
    ex_pkg::OP_SLL, ex_pkg::OP_SRL, ex_pkg::OP_SLT, ex_pkg::OP_SLTU
  };

  logic              clk;
  logic              rst_n;
  logic              in_valid_i;
  ex_pkg::ex_instr_t in_instr_i;
  logic              in_ready_o;
  logic              out_valid_o;
  ex_pkg::ex_wb_t    out_wb_o;
  logic              out_ready_i;

  // Scoreboard and stimulus state
  ex_pkg::ex_wb_t    expected_q [$];
  logic [31:0]       stim_state;
  logic [31:0]       ready_state;
  logic              random_ready;
  int                cycle_count;
  logic              stalled_q;
  ex_pkg::ex_wb_t    stalled_wb;

  ex_stage #(
    .DIV_BITS_PER_CYCLE (1)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_instr_i  (in_instr_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_wb_o    (out_wb_o),
    .out_ready_i (out_ready_i)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  function automatic ex_pkg::ex_instr_t make_instr(input ex_pkg::ex_op_e op,
      input logic [31:0] a, input logic [31:0] b, input logic [31:0] target,
      input logic [4:0] rd);
    ex_pkg::ex_instr_t instr;
    instr.op        = op;
    instr.operand_a = a;
    instr.operand_b = b;
    instr.target    = target;
    instr.rd        = rd;
    return instr;
  endfunction

  // Expected EX/WB contents straight from the instruction semantics
  function automatic ex_pkg::ex_wb_t model_wb(input ex_pkg::ex_instr_t instr);
    ex_pkg::ex_wb_t wb;
    logic [31:0]    a;
    logic [31:0]    b;
    a                = instr.operand_a;
    b                = instr.operand_b;
    wb               = '0;
    wb.rd            = instr.rd;
    wb.branch_target = instr.target;
    wb.is_branch     = instr.op inside {ex_pkg::OP_BEQ, ex_pkg::OP_BNE, ex_pkg::OP_BLT};
    // x0 and branches never write the register file
    wb.rf_we         = !wb.is_branch && (instr.rd != 5'd0);
    case (instr.op)
      ex_pkg::OP_ADD:  wb.wdata = a + b;
      ex_pkg::OP_SUB:  wb.wdata = a - b;
      ex_pkg::OP_AND:  wb.wdata = a & b;
      ex_pkg::OP_OR:   wb.wdata = a | b;
      ex_pkg::OP_XOR:  wb.wdata = a ^ b;
      ex_pkg::OP_SLL:  wb.wdata = a << b[4:0];
      ex_pkg::OP_SRL:  wb.wdata = a >> b[4:0];
      ex_pkg::OP_SLT:  wb.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ex_pkg::OP_SLTU: wb.wdata = (a < b) ? 32'd1 : 32'd0;
      ex_pkg::OP_BEQ:  wb.branch_taken = (a == b);
      ex_pkg::OP_BNE:  wb.branch_taken = (a != b);
      ex_pkg::OP_BLT:  wb.branch_taken = ($signed(a) < $signed(b));
      // Divide by zero gives all ones, remainder by zero the dividend
      ex_pkg::OP_DIVU: wb.wdata = (b == 32'd0) ? 32'hffff_ffff : a / b;
      ex_pkg::OP_REMU: wb.wdata = (b == 32'd0) ? a : a % b;
      default:         wb.wdata = '0;
    endcase
    return wb;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
      input logic [127:0] exp);
    if (got !== exp) begin
      $display("[FAIL] time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_output(input ex_pkg::ex_wb_t got);
    ex_pkg::ex_wb_t exp;
    if (expected_q.size() == 0) begin
      abort_run("Output transfer seen with no instruction outstanding");
    end else begin
      exp = expected_q.pop_front();
      check_value("out_wb_o.rf_we", got.rf_we, exp.rf_we);
      check_value("out_wb_o.rd", got.rd, exp.rd);
      check_value("out_wb_o.is_branch", got.is_branch, exp.is_branch);
      check_value("out_wb_o.branch_taken", got.branch_taken, exp.branch_taken);
      if (exp.is_branch) begin
        check_value("out_wb_o.branch_target", got.branch_target, exp.branch_target);
      end else begin
        check_value("out_wb_o.wdata", got.wdata, exp.wdata);
      end
    end
  endtask

  // Holds the instruction until accepted, returns the stalled cycles
  task automatic send_instr(input ex_pkg::ex_instr_t instr, output int waits);
    logic accepted;
    waits      = 0;
    accepted   = 1'b0;
    in_valid_i = 1'b1;
    in_instr_i = instr;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready_o;
      if (accepted) begin
        expected_q.push_back(model_wb(instr));
      end else begin
        waits++;
      end
      @(posedge clk);
      #1;
    end
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (expected_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor, ready driver and timeout
  //////////////////////////////////////////////////////////////////////

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (stalled_q) begin
        check_value("out_valid_o held", out_valid_o, 1'b1);
        check_value("out_wb_o held", out_wb_o, stalled_wb);
      end
      if (out_valid_o && out_ready_i) begin
        check_output(out_wb_o);
      end
      stalled_q  = out_valid_o && !out_ready_i;
      stalled_wb = out_wb_o;
    end
  end

  always @(posedge clk) begin
    #1;
    if (random_ready) begin
      ready_state = xorshift32(ready_state);
      out_ready_i = ready_state[3];
    end else begin
      out_ready_i = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      abort_run($sformatf("Timeout, run hung after %0d cycles", cycle_count));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    @(negedge clk);
    check_value("out_valid_o after reset", out_valid_o, 1'b0);
    check_value("in_ready_o after reset", in_ready_o, 1'b1);
    @(posedge clk);
    #1;
  endtask

  task automatic test_alu();
    logic [31:0] rnd;
    logic [4:0]  rd;
    int          waits;
    for (int i = 0; i < 9; i++) begin
      for (int r = 0; r < ALU_REPS; r++) begin
        rnd = next_rand();
        // First repetition of each opcode targets x0
        rd  = (r == 0) ? 5'd0 : rnd[4:0];
        send_instr(make_instr(ALU_OPS[i], next_rand(), next_rand(), next_rand(), rd), waits);
      end
    end
    wait_drain();
  endtask

  task automatic test_branch();
    logic [31:0] a;
    int          waits;
    a = next_rand();
    send_instr(make_instr(ex_pkg::OP_BEQ, a, a, next_rand(), 5'd3), waits);
    send_instr(make_instr(ex_pkg::OP_BEQ, a, a + 32'd1, next_rand(), 5'd4), waits);
    send_instr(make_instr(ex_pkg::OP_BNE, a, a + 32'd1, next_rand(), 5'd5), waits);
    send_instr(make_instr(ex_pkg::OP_BNE, a, a, next_rand(), 5'd6), waits);
    // Signed compare, negative below positive
    send_instr(make_instr(ex_pkg::OP_BLT, -32'sd5, 32'd3, next_rand(), 5'd7), waits);
    send_instr(make_instr(ex_pkg::OP_BLT, 32'd3, -32'sd5, next_rand(), 5'd8), waits);
    wait_drain();
  endtask

  task automatic test_div();
    logic [31:0] a;
    logic [31:0] b;
    int          waits;
    for (int r = 0; r < 4; r++) begin
      a = next_rand();
      b = next_rand() >> next_rand() % 32;
      send_instr(make_instr(ex_pkg::OP_DIVU, a, b, 32'd0, 5'd10), waits);
      send_instr(make_instr(ex_pkg::OP_REMU, a, b, 32'd0, 5'd11), waits);
    end
    a = next_rand();
    send_instr(make_instr(ex_pkg::OP_DIVU, a, 32'd0, 32'd0, 5'd12), waits);
    send_instr(make_instr(ex_pkg::OP_REMU, a, 32'd0, 32'd0, 5'd13), waits);
    // Divisor above dividend
    a = next_rand() >> 8;
    send_instr(make_instr(ex_pkg::OP_DIVU, a, a + 32'd5, 32'd0, 5'd14), waits);
    send_instr(make_instr(ex_pkg::OP_REMU, a, a + 32'd5, 32'd0, 5'd15), waits);
    send_instr(make_instr(ex_pkg::OP_DIVU, 32'hffff_ffff, 32'd1, 32'd0, 5'd16), waits);
    send_instr(make_instr(ex_pkg::OP_REMU, 32'hffff_ffff, 32'd1, 32'd0, 5'd17), waits);
    wait_drain();
  endtask

  task automatic test_mixed();
    logic [31:0]    rnd;
    ex_pkg::ex_op_e op;
    int             waits;
    random_ready = 1'b1;
    for (int n = 0; n < NUM_MIXED; n++) begin
      rnd = next_rand();
      op  = ex_pkg::ex_op_e'(rnd % 14);
      send_instr(make_instr(op, next_rand(), next_rand() >> rnd[8:4], next_rand(), rnd[31:27]),
                 waits);
    end
    wait_drain();
    random_ready = 1'b0;
    out_ready_i  = 1'b1;
  endtask

  task automatic test_back_to_back();
    logic [31:0] rnd;
    int          waits;
    for (int n = 0; n < NUM_B2B; n++) begin
      rnd = next_rand();
      send_instr(make_instr(ALU_OPS[rnd % 9], next_rand(), next_rand(), 32'd0, rnd[14:10]),
                 waits);
      // Consumer never stalls, so every offer is taken at once
      check_value("in_ready_o stall cycles", waits, 0);
    end
    wait_drain();
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_valid_i   = 1'b0;
    in_instr_i   = '0;
    out_ready_i  = 1'b1;
    random_ready = 1'b0;
    stim_state   = SEED;
    ready_state  = SEED ^ 32'h5a5a_a5a5;
    cycle_count  = 0;
    stalled_q    = 1'b0;
    stalled_wb   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset();
    test_alu();
    test_branch();
    test_div();
    test_mixed();
    test_back_to_back();

    // A few idle cycles let the monitor catch any output that follows the last one
    repeat (4) @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: project.f
hdl/ex_pkg.sv
hdl/ex_decode.sv
hdl/ex_alu.sv
hdl/ex_div.sv
hdl/ex_result.sv
hdl/ex_stage.sv
verif/tb_ex_stage.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= === FAIL ===

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	elif [ $$status -ne 0 ]; then \
	  echo "Simulator exited with status $$status"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
